//--- Makefile
# Verilator build and run for the SDRAM scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_sdram_sched
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' compile.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) compile.f tests/sdram_sched_stim.txt
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
logic/sdram_sched_pkg.sv
logic/sdram_req_decode.sv
logic/sdram_bank_timers.sv
logic/sdram_refresh_timer.sv
logic/sdram_cmd_issue.sv
logic/sdram_rd_return.sv
logic/sdram_sched_top.sv
tests/sdram_sched_assert.sv
tests/sdram_sched_checker.sv
tests/tb_sdram_sched.sv

//--- logic/sdram_bank_timers.sv
////////////////////////////////////////////////////////////
// Per-bank tRCD/tRP/tRAS counters and a shared tRC counter,
// loaded from the commands seen on the SDRAM command bus
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_bank_timers
  import sdram_sched_pkg::*;
#(
  parameter int T_RCD = 3,
  parameter int T_RP  = 3,
  parameter int T_RAS = 6,
  parameter int T_RC  = 9
)
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire sdram_cmd_e cmd_i,
  input  wire bank_t      ba_i,
  input  wire sd_addr_t   addr_cmd_i,
  output logic [BANKS-1:0] act_ok_o,
  output logic [BANKS-1:0] rw_ok_o,
  output logic [BANKS-1:0] pre_ok_o,
  output logic             ref_ok_o
);

  localparam int CNT_W = $clog2(T_RCD + T_RP + T_RAS + T_RC);
  typedef logic [CNT_W-1:0] cnt_t;

  // Command is seen one cycle late and the next one takes a
  // cycle to register, so each gap is loaded as T - 2
  localparam cnt_t RCD_LD = cnt_t'(T_RCD - 2);
  localparam cnt_t RP_LD  = cnt_t'(T_RP - 2);
  localparam cnt_t RAS_LD = cnt_t'(T_RAS - 2);
  localparam cnt_t RC_LD  = cnt_t'(T_RC - 2);

  cnt_t rcd_cnt [BANKS];
  cnt_t rp_cnt  [BANKS];
  cnt_t ras_cnt [BANKS];
  cnt_t rc_cnt;
  logic rc_ok;
  logic [BANKS-1:0] rp_ok;

  function automatic cnt_t count(input logic load, input cnt_t ld_val, input cnt_t cnt);
    if (load)
      return ld_val;
    return (cnt != '0) ? cnt - 1'b1 : cnt;
  endfunction

  for (genvar b = 0; b < BANKS; b++)
  begin : g_bank
    logic act_hit;
    logic pre_hit;

    assign act_hit = (cmd_i == CMD_ACT) && (ba_i == bank_t'(b));
    assign pre_hit = (cmd_i == CMD_PRE) && (addr_cmd_i[A10_BIT] || ba_i == bank_t'(b));

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        rcd_cnt[b] <= '0;
        ras_cnt[b] <= '0;
        rp_cnt[b]  <= '0;
      end
      else
      begin
        rcd_cnt[b] <= count(act_hit, RCD_LD, rcd_cnt[b]);
        ras_cnt[b] <= count(act_hit, RAS_LD, ras_cnt[b]);
        rp_cnt[b]  <= count(pre_hit, RP_LD, rp_cnt[b]);
      end
    end

    assign rp_ok[b]    = (rp_cnt[b] == '0);
    assign rw_ok_o[b]  = (rcd_cnt[b] == '0);
    assign pre_ok_o[b] = (ras_cnt[b] == '0);
    assign act_ok_o[b] = rp_ok[b] && rc_ok;
  end

  // Global tRC, restarted by REF and by any ACT
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rc_cnt <= '0;
    else
      rc_cnt <= count(cmd_i == CMD_REF || cmd_i == CMD_ACT, RC_LD, rc_cnt);
  end

  assign rc_ok    = (rc_cnt == '0);
  assign ref_ok_o = &rp_ok && rc_ok;

endmodule : sdram_bank_timers

`default_nettype wire

//--- logic/sdram_cmd_issue.sv
////////////////////////////////////////////////////////////
// Picks the next SDRAM command from the slot, the bank timers
// and the refresh request, and registers it onto the pins
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_issue
  import sdram_sched_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             slot_valid_i,
  input  wire logic             slot_we_i,
  input  wire bank_t            slot_bank_i,
  input  wire row_t             slot_row_i,
  input  wire col_t             slot_col_i,
  input  wire dq_t              slot_wdata_i,
  input  wire logic             row_hit_i,
  input  wire logic             bank_open_i,
  input  wire logic             any_open_i,
  input  wire logic [BANKS-1:0] act_ok_i,
  input  wire logic [BANKS-1:0] rw_ok_i,
  input  wire logic [BANKS-1:0] pre_ok_i,
  input  wire logic             ref_ok_i,
  input  wire logic             ref_pending_i,
  output logic                  slot_take_o,
  output sdram_cmd_e            sd_cmd_o,
  output bank_t                 sd_ba_o,
  output sd_addr_t              sd_addr_o,
  output dq_t                   sd_dq_o,
  output logic                  sd_dqoe_o
);

  issue_st_e  st_q, st_d;
  sdram_cmd_e cmd_d;
  bank_t      ba_d;
  sd_addr_t   addr_d;

  ////////////////////////////////////////////////////////////
  // Next command
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    st_d        = st_q;
    cmd_d       = CMD_NOP;
    ba_d        = slot_bank_i;
    addr_d      = '0;
    slot_take_o = 1'b0;

    // Table and timers see a command one cycle after it is issued,
    // so nothing goes out right behind another command
    if (sd_cmd_o == CMD_NOP)
    begin
      case (st_q)
        ST_REF_WAIT:
          if (ref_ok_i)
          begin
            cmd_d = CMD_REF;
            st_d  = ST_RUN;
          end
        default:
          if (ref_pending_i)
          begin
            if (any_open_i)
            begin
              if (&pre_ok_i)
              begin
                cmd_d           = CMD_PRE;
                addr_d[A10_BIT] = 1'b1;
                st_d            = ST_REF_WAIT;
              end
            end
            else if (ref_ok_i)
              cmd_d = CMD_REF;
          end
          else if (slot_valid_i)
          begin
            if (row_hit_i)
            begin
              if (rw_ok_i[slot_bank_i])
              begin
                cmd_d              = slot_we_i ? CMD_WR : CMD_RD;
                addr_d[COL_W-1:0]  = slot_col_i;
                slot_take_o        = 1'b1;
              end
            end
            else if (!bank_open_i)
            begin
              if (act_ok_i[slot_bank_i])
              begin
                cmd_d             = CMD_ACT;
                addr_d[ROW_W-1:0] = slot_row_i;
              end
            end
            else if (pre_ok_i[slot_bank_i])
              cmd_d = CMD_PRE;
          end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      st_q      <= ST_RUN;
      sd_cmd_o  <= CMD_NOP;
      sd_dqoe_o <= 1'b0;
    end
    else
    begin
      st_q      <= st_d;
      sd_cmd_o  <= cmd_d;
      sd_dqoe_o <= (cmd_d == CMD_WR);
    end
  end

  // Address, bank and write data ride along with the command
  always_ff @(posedge clk_i)
  begin
    sd_ba_o   <= ba_d;
    sd_addr_o <= addr_d;
    if (slot_take_o && slot_we_i)
      sd_dq_o <= slot_wdata_i;
  end

endmodule : sdram_cmd_issue

`default_nettype wire

//--- logic/sdram_rd_return.sv
////////////////////////////////////////////////////////////
// CAS-latency marker line; captures DQ and flags each read
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_rd_return
  import sdram_sched_pkg::*;
#(
  parameter int CAS_LAT = 3
)
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire sdram_cmd_e cmd_i,
  input  wire dq_t        sd_dq_i,
  output logic            rd_valid_o,
  output dq_t             rd_data_o
);

  // One marker per RD, several may be in flight
  logic [CAS_LAT-1:0] mark_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mark_q     <= '0;
      rd_valid_o <= 1'b0;
    end
    else
    begin
      mark_q[0] <= (cmd_i == CMD_RD);
      for (int i = 1; i < CAS_LAT; i++)
        mark_q[i] <= mark_q[i-1];
      rd_valid_o <= mark_q[CAS_LAT-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mark_q[CAS_LAT-1])
      rd_data_o <= sd_dq_i;
  end

endmodule : sdram_rd_return

`default_nettype wire

//--- logic/sdram_refresh_timer.sv
////////////////////////////////////////////////////////////
// Refresh interval tick and a small pending-refresh count
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer
  import sdram_sched_pkg::*;
#(
  parameter int T_REFI = 400
)
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire sdram_cmd_e cmd_i,
  output logic            ref_pending_o
);

  localparam int REFI_W = $clog2(T_REFI);
  typedef logic [REFI_W-1:0] refi_t;

  refi_t      interval_q;
  logic [2:0] pending_q;
  logic       tick;
  logic       ref_seen;

  assign tick     = (interval_q == '0);
  assign ref_seen = (cmd_i == CMD_REF);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      interval_q <= refi_t'(T_REFI - 1);
      pending_q  <= '0;
    end
    else
    begin
      interval_q <= tick ? refi_t'(T_REFI - 1) : interval_q - 1'b1;
      // Tick and REF together leave the count alone
      if (tick && !ref_seen && pending_q != 3'd7)
        pending_q <= pending_q + 1'b1;
      else if (ref_seen && !tick && pending_q != 3'd0)
        pending_q <= pending_q - 1'b1;
    end
  end

  assign ref_pending_o = |pending_q;

endmodule : sdram_refresh_timer

`default_nettype wire

//--- logic/sdram_req_decode.sv
////////////////////////////////////////////////////////////
// Request slot with address split and open-row table; tells
// the issue stage whether the held access hits an open row
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_req_decode
  import sdram_sched_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       req_i,
  input  wire logic       we_i,
  input  wire addr_t      addr_i,
  input  wire dq_t        wdata_i,
  input  wire logic       slot_take_i,
  input  wire sdram_cmd_e cmd_i,
  input  wire bank_t      ba_i,
  input  wire sd_addr_t   addr_cmd_i,
  output logic            ack_o,
  output logic            slot_valid_o,
  output logic            slot_we_o,
  output bank_t           slot_bank_o,
  output row_t            slot_row_o,
  output col_t            slot_col_o,
  output dq_t             slot_wdata_o,
  output logic            row_hit_o,
  output logic            bank_open_o,
  output logic            any_open_o
);

  logic             accept;
  logic [BANKS-1:0] open_q;
  row_t             row_q [BANKS];

  // Slot frees on the same edge the RD/WR is registered
  assign accept = req_i && (!slot_valid_o || slot_take_i);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o        <= 1'b0;
      slot_valid_o <= 1'b0;
    end
    else
    begin
      ack_o        <= accept;
      slot_valid_o <= accept || (slot_valid_o && !slot_take_i);
    end
  end

  // Host address is {row, bank, col}
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      slot_we_o    <= we_i;
      slot_col_o   <= addr_i[COL_W-1:0];
      slot_bank_o  <= addr_i[COL_W +: BA_W];
      slot_row_o   <= addr_i[COL_W+BA_W +: ROW_W];
      slot_wdata_o <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Open-row table, follows the command bus
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      open_q <= '0;
    else if (cmd_i == CMD_ACT)
      open_q[ba_i] <= 1'b1;
    else if (cmd_i == CMD_PRE)
    begin
      if (addr_cmd_i[A10_BIT])
        open_q <= '0;
      else
        open_q[ba_i] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_i == CMD_ACT)
      row_q[ba_i] <= addr_cmd_i[ROW_W-1:0];
  end

  assign bank_open_o = open_q[slot_bank_o];
  assign row_hit_o   = slot_valid_o && bank_open_o && (row_q[slot_bank_o] == slot_row_o);
  assign any_open_o  = |open_q;

endmodule : sdram_req_decode

`default_nettype wire

//--- logic/sdram_sched_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, vector types and command encodings for the
// SDRAM scheduler, imported by every pipeline stage
////////////////////////////////////////////////////////////

`default_nettype none

package sdram_sched_pkg;

  // Geometry of the attached SDRAM
  localparam int ROW_W     = 13;
  localparam int BA_W      = 2;
  localparam int COL_W     = 9;
  localparam int BANKS     = 4;
  localparam int ADDR_W    = ROW_W + BA_W + COL_W;
  localparam int DQ_W      = 16;
  localparam int SD_ADDR_W = 13;

  // All-banks bit for PRE, must stay clear for single-bank PRE
  localparam int A10_BIT   = 10;

  typedef logic [ROW_W-1:0]     row_t;
  typedef logic [BA_W-1:0]      bank_t;
  typedef logic [COL_W-1:0]     col_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DQ_W-1:0]      dq_t;
  typedef logic [SD_ADDR_W-1:0] sd_addr_t;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  typedef enum logic {
    ST_RUN      = 1'b0,
    ST_REF_WAIT = 1'b1
  } issue_st_e;

endpackage : sdram_sched_pkg

`default_nettype wire

//--- logic/sdram_sched_top.sv
////////////////////////////////////////////////////////////
// Scheduler top level; fixes the SDRAM timing and connects
// decode, timers, issue and read return around the command bus
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_sched_top
  import sdram_sched_pkg::*;
#(
  parameter int T_RCD   = 3,
  parameter int T_RP    = 3,
  parameter int T_RAS   = 6,
  parameter int T_RC    = 9,
  parameter int CAS_LAT = 3,
  parameter int T_REFI  = 400
)
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       req_i,
  input  wire logic       we_i,
  input  wire addr_t      addr_i,
  input  wire dq_t        wdata_i,
  output logic            ack_o,
  output logic            rd_valid_o,
  output dq_t             rd_data_o,
  output sdram_cmd_e      sd_cmd_o,
  output bank_t           sd_ba_o,
  output sd_addr_t        sd_addr_o,
  output dq_t             sd_dq_o,
  output logic            sd_dqoe_o,
  input  wire dq_t        sd_dq_i
);

  logic             slot_valid, slot_we, slot_take;
  bank_t            slot_bank;
  row_t             slot_row;
  col_t             slot_col;
  dq_t              slot_wdata;
  logic             row_hit, bank_open, any_open;
  logic [BANKS-1:0] act_ok, rw_ok, pre_ok;
  logic             ref_ok, ref_pending;

  sdram_req_decode u_decode (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i,
    .slot_take_i (slot_take),    .cmd_i (sd_cmd_o),
    .ba_i (sd_ba_o),             .addr_cmd_i (sd_addr_o),
    .ack_o,
    .slot_valid_o (slot_valid),  .slot_we_o (slot_we),
    .slot_bank_o (slot_bank),    .slot_row_o (slot_row),
    .slot_col_o (slot_col),      .slot_wdata_o (slot_wdata),
    .row_hit_o (row_hit),        .bank_open_o (bank_open),
    .any_open_o (any_open)
  );

  sdram_bank_timers #(.T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_RC(T_RC)) u_timers (
    .clk_i, .rst_ni,
    .cmd_i (sd_cmd_o), .ba_i (sd_ba_o), .addr_cmd_i (sd_addr_o),
    .act_ok_o (act_ok), .rw_ok_o (rw_ok), .pre_ok_o (pre_ok), .ref_ok_o (ref_ok)
  );

  sdram_refresh_timer #(.T_REFI(T_REFI)) u_refresh (
    .clk_i, .rst_ni, .cmd_i (sd_cmd_o), .ref_pending_o (ref_pending)
  );

  sdram_cmd_issue u_issue (
    .clk_i, .rst_ni,
    .slot_valid_i (slot_valid),  .slot_we_i (slot_we),
    .slot_bank_i (slot_bank),    .slot_row_i (slot_row),
    .slot_col_i (slot_col),      .slot_wdata_i (slot_wdata),
    .row_hit_i (row_hit),        .bank_open_i (bank_open),
    .any_open_i (any_open),
    .act_ok_i (act_ok), .rw_ok_i (rw_ok), .pre_ok_i (pre_ok),
    .ref_ok_i (ref_ok),          .ref_pending_i (ref_pending),
    .slot_take_o (slot_take),
    .sd_cmd_o, .sd_ba_o, .sd_addr_o, .sd_dq_o, .sd_dqoe_o
  );

  sdram_rd_return #(.CAS_LAT(CAS_LAT)) u_rd_return (
    .clk_i, .rst_ni, .cmd_i (sd_cmd_o), .sd_dq_i, .rd_valid_o, .rd_data_o
  );

endmodule : sdram_sched_top

`default_nettype wire

//--- tests/sdram_sched_assert.sv
////////////////////////////////////////////////////////////
// Concurrent checks on the command issue stage, bound in
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_sched_assert
  import sdram_sched_pkg::*;
(
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire sdram_cmd_e sd_cmd_i,
  input wire logic       sd_dqoe_i,
  input wire logic       slot_take_i,
  input wire logic       any_open_i
);

  // Refresh needs every bank closed
  ref_all_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sd_cmd_i == CMD_REF) |-> !any_open_i)
    else $error("REF issued while a bank is open");

  // DQ is only driven for a write
  dqoe_with_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sd_dqoe_i |-> (sd_cmd_i == CMD_WR))
    else $error("DQ output enable without WR");

  take_with_rw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot_take_i |=> (sd_cmd_i == CMD_RD || sd_cmd_i == CMD_WR))
    else $error("slot taken without RD or WR");

endmodule : sdram_sched_assert

bind sdram_cmd_issue sdram_sched_assert u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .sd_cmd_i    (sd_cmd_o),
  .sd_dqoe_i   (sd_dqoe_o),
  .slot_take_i (slot_take_o),
  .any_open_i  (any_open_i)
);

`default_nettype wire

//--- tests/sdram_sched_checker.sv
////////////////////////////////////////////////////////////
// Watches host and SDRAM ports; checks data, order, timing
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdram_sched_checker
  import sdram_sched_pkg::*;
#(
  parameter int T_RCD   = 3,
  parameter int T_RP    = 3,
  parameter int T_RAS   = 6,
  parameter int T_RC    = 9,
  parameter int CAS_LAT = 3,
  parameter int T_REFI  = 400
)
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       ack_i,
  input  wire logic       rd_valid_i,
  input  wire dq_t        rd_data_i,
  input  wire sdram_cmd_e sd_cmd_i,
  input  wire bank_t      sd_ba_i,
  input  wire sd_addr_t   sd_addr_i,
  input  wire dq_t        sd_wdata_i,
  input  wire logic       sd_dqoe_i,
  input  wire logic       exp_push_i,
  input  wire logic       exp_we_i,
  input  wire addr_t      exp_addr_i,
  input  wire dq_t        exp_data_i,
  input  wire logic       done_i,
  input  var  int         req_count_i,
  output int              data_err_o,
  output int              timing_err_o,
  output int              proto_err_o,
  output logic            idle_o,
  output logic            final_o
);

  // Accesses not yet issued, oldest first
  addr_t acc_addr_q[$];
  logic  acc_we_q[$];
  dq_t   acc_data_q[$];
  // Reads issued, waiting for data
  dq_t   rd_exp_q[$];
  int    rd_cyc_q[$];

  logic [BANKS-1:0] open_q = '0;
  row_t open_row [BANKS];
  int   last_act [BANKS] = '{default: -1000};
  int   last_pre [BANKS] = '{default: -1000};
  int   last_ref  = -1000;
  int   cyc       = 0;
  int   ref_cnt   = 0;
  int   ack_cnt   = 0;
  logic first     = 1'b1;

  initial
  begin
    data_err_o   = 0;
    timing_err_o = 0;
    proto_err_o  = 0;
    final_o      = 1'b0;
  end

  // kind 0 data, 1 timing, 2 protocol
  task automatic flag(input int kind, input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    if (kind == 0)
      data_err_o++;
    else if (kind == 1)
      timing_err_o++;
    else
      proto_err_o++;
  endtask

  task automatic check_gap(input int since, input int min_gap, input string what);
    if (cyc - since < min_gap)
      flag(1, $sformatf("%s gap %0d, needs %0d", what, cyc - since, min_gap));
  endtask

  function automatic row_t row_of(input addr_t a);
    return a[COL_W+BA_W +: ROW_W];
  endfunction

  function automatic bank_t bank_of(input addr_t a);
    return a[COL_W +: BA_W];
  endfunction

  always @(posedge clk_i)
  begin
    bank_t b;
    addr_t fa;
    dq_t   exp;
    int    c;
    if (rst_ni)
    begin
      cyc++;
      b = sd_ba_i;
      if (first && (sd_cmd_i != CMD_NOP || ack_i || rd_valid_i))
        flag(2, "outputs not idle after reset");
      first = 1'b0;
      if (sd_dqoe_i !== (sd_cmd_i == CMD_WR))
        flag(2, "DQ output enable does not match WR");
      if (exp_push_i)
      begin
        acc_addr_q.push_back(exp_addr_i);
        acc_we_q.push_back(exp_we_i);
        acc_data_q.push_back(exp_data_i);
      end
      if (ack_i)
        ack_cnt++;
      fa = (acc_addr_q.size() != 0) ? acc_addr_q[0] : '1;
      case (sd_cmd_i)
        CMD_ACT:
        begin
          if (open_q[b])
            flag(2, $sformatf("ACT to open bank %0d", b));
          if (acc_addr_q.size() == 0 || bank_of(fa) != b || row_of(fa) != sd_addr_i)
            flag(2, "ACT does not match the pending access");
          check_gap(last_pre[b], T_RP, "PRE to ACT");
          check_gap(last_ref, T_RC, "REF to ACT");
          open_q[b]   = 1'b1;
          open_row[b] = sd_addr_i;
          last_act[b] = cyc;
        end
        CMD_PRE:
          if (sd_addr_i[A10_BIT])
          begin
            for (int i = 0; i < BANKS; i++)
            begin
              if (open_q[i])
                check_gap(last_act[i], T_RAS, "ACT to PRE-all");
              last_pre[i] = cyc;
            end
            open_q = '0;
          end
          else
          begin
            if (!open_q[b])
              flag(2, $sformatf("PRE to idle bank %0d", b));
            if (acc_addr_q.size() == 0 || bank_of(fa) != b || row_of(fa) == open_row[b])
              flag(2, "PRE without a row conflict");
            check_gap(last_act[b], T_RAS, "ACT to PRE");
            open_q[b]   = 1'b0;
            last_pre[b] = cyc;
          end
        CMD_RD, CMD_WR:
          if (acc_addr_q.size() == 0)
            flag(2, "RD/WR with no pending access");
          else
          begin
            if (bank_of(fa) != b || fa[COL_W-1:0] != sd_addr_i[COL_W-1:0]
                || !open_q[b] || open_row[b] != row_of(fa)
                || acc_we_q[0] != (sd_cmd_i == CMD_WR))
              flag(2, $sformatf("RD/WR mismatch for address %h", fa));
            if (sd_cmd_i == CMD_WR && sd_wdata_i !== acc_data_q[0])
              flag(0, $sformatf("write data %h, expected %h", sd_wdata_i, acc_data_q[0]));
            check_gap(last_act[b], T_RCD, "ACT to RD/WR");
            if (sd_cmd_i == CMD_RD)
            begin
              rd_exp_q.push_back(acc_data_q[0]);
              rd_cyc_q.push_back(cyc);
            end
            void'(acc_addr_q.pop_front());
            void'(acc_we_q.pop_front());
            void'(acc_data_q.pop_front());
          end
        CMD_REF:
        begin
          if (open_q != '0)
            flag(2, "REF with a bank open");
          check_gap(last_ref, T_RC, "REF to REF");
          ref_cnt++;
          last_ref = cyc;
        end
        default:
          ;
      endcase
      if (rd_valid_i)
      begin
        if (rd_cyc_q.size() == 0)
          flag(2, "rd_valid_o with no read in flight");
        else
        begin
          c   = rd_cyc_q.pop_front();
          exp = rd_exp_q.pop_front();
          if (cyc - c != CAS_LAT + 1)
            flag(1, $sformatf("read latency %0d, expected %0d", cyc - c, CAS_LAT + 1));
          if (rd_data_i !== exp)
            flag(0, $sformatf("read data %h, expected %h", rd_data_i, exp));
        end
      end
      if (done_i && !final_o)
      begin
        if (acc_addr_q.size() != 0 || rd_cyc_q.size() != 0)
          flag(2, "accesses still outstanding at the end");
        if (ack_cnt != req_count_i)
          flag(2, $sformatf("%0d acks for %0d requests", ack_cnt, req_count_i));
        if (ref_cnt < cyc / T_REFI - 1)
          flag(1, $sformatf("%0d REFs in %0d cycles", ref_cnt, cyc));
        final_o = 1'b1;
      end
      idle_o = (acc_addr_q.size() == 0) && (rd_cyc_q.size() == 0);
    end
  end

endmodule : sdram_sched_checker

`default_nettype wire

//--- tests/sdram_sched_stim.txt
// Columns: op (1 write, 0 read), address {row,bank,col}, write data, expected read
// Rows differ within bank 0 to force conflicts; banks 1 to 3 open in parallel
1 000805 1111 0000
1 000806 2222 0000
0 000805 0000 1111
0 000806 0000 2222
1 001005 3333 0000
0 000805 0000 1111
0 001005 0000 3333
1 000A03 4444 0000
1 003C10 5555 0000
1 080601 6666 0000
0 000A03 0000 4444
0 003C10 0000 5555
0 080601 0000 6666
1 000806 7777 0000
0 000806 0000 7777
0 001005 0000 3333
0 000805 0000 1111
0 000A03 0000 4444

//--- tests/tb_sdram_sched.sv
////////////////////////////////////////////////////////////
// Testbench top: clock, reset, stimulus from file, SDRAM
// memory model and watchdog; prints the final result
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_sdram_sched;
  import sdram_sched_pkg::*;

  localparam int CAS_LAT = 3;
  localparam int T_REFI  = 400;
  localparam int MAX_ACC = 64;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0;
  logic we_i = 1'b0;
  addr_t addr_i = '0;
  dq_t wdata_i = '0;
  dq_t sd_dq_i;
  logic ack_o, rd_valid_o, sd_dqoe_o;
  dq_t rd_data_o, sd_dq_o;
  sdram_cmd_e sd_cmd_o;
  bank_t sd_ba_o;
  sd_addr_t sd_addr_o;

  logic exp_push = 1'b0;
  logic exp_we = 1'b0;
  addr_t exp_addr = '0;
  dq_t exp_data = '0;
  logic done = 1'b0;
  logic loaded = 1'b0;
  int n_acc = 0;
  int run_cyc = 0;
  int data_err, timing_err, proto_err;
  logic idle, final_done;

  // Four words per access: op, address, write data, expected read
  logic [23:0] stim [0:4*MAX_ACC-1];

  // Memory model
  dq_t  mem [addr_t];
  row_t open_row [BANKS];
  dq_t  dq_pipe [CAS_LAT];

  sdram_sched_top #(.CAS_LAT(CAS_LAT), .T_REFI(T_REFI)) dut (.*);

  sdram_sched_checker #(.CAS_LAT(CAS_LAT), .T_REFI(T_REFI)) u_checker (
    .clk_i, .rst_ni, .ack_i (ack_o), .rd_valid_i (rd_valid_o), .rd_data_i (rd_data_o),
    .sd_cmd_i (sd_cmd_o), .sd_ba_i (sd_ba_o), .sd_addr_i (sd_addr_o),
    .sd_wdata_i (sd_dq_o), .sd_dqoe_i (sd_dqoe_o),
    .exp_push_i (exp_push), .exp_we_i (exp_we), .exp_addr_i (exp_addr),
    .exp_data_i (exp_data), .done_i (done), .req_count_i (n_acc),
    .data_err_o (data_err), .timing_err_o (timing_err), .proto_err_o (proto_err),
    .idle_o (idle), .final_o (final_done)
  );

  initial
  begin
    forever #5 clk_i = ~clk_i;
  end

  // Cycles since reset release
  always @(posedge clk_i)
  begin
    if (rst_ni)
      run_cyc <= run_cyc + 1;
  end

  // Read data appears CAS_LAT cycles after RD
  assign sd_dq_i = dq_pipe[CAS_LAT-1];

  always @(posedge clk_i or negedge rst_ni)
  begin
    addr_t key;
    if (!rst_ni)
    begin
      for (int i = 0; i < CAS_LAT; i++)
        dq_pipe[i] <= '0;
    end
    else
    begin
      key = {open_row[sd_ba_o], sd_ba_o, sd_addr_o[COL_W-1:0]};
      if (sd_cmd_o == CMD_ACT)
        open_row[sd_ba_o] <= sd_addr_o[ROW_W-1:0];
      if (sd_cmd_o == CMD_WR)
        mem[key] = sd_dq_o;
      dq_pipe[0] <= (sd_cmd_o == CMD_RD && mem.exists(key)) ? mem[key] : '0;
      for (int i = 1; i < CAS_LAT; i++)
        dq_pipe[i] <= dq_pipe[i-1];
    end
  end

  // Holds the request until ack, then hands it to the checker
  task automatic send_request(input int idx);
    req_i   = 1'b1;
    we_i    = stim[4*idx][0];
    addr_i  = addr_t'(stim[4*idx+1]);
    wdata_i = dq_t'(stim[4*idx+2]);
    do
    begin
      @(negedge clk_i);
      exp_push = 1'b0;
    end
    while (!ack_o);
    req_i    = 1'b0;
    exp_push = 1'b1;
    exp_we   = we_i;
    exp_addr = addr_i;
    exp_data = we_i ? wdata_i : dq_t'(stim[4*idx+3]);
  endtask

  initial
  begin
    for (int i = 0; i < 4*MAX_ACC; i++)
      stim[i] = '1;
    $readmemh("tests/sdram_sched_stim.txt", stim);
    while (n_acc < MAX_ACC && stim[4*n_acc] != '1)
      n_acc++;
    loaded = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < n_acc; i++)
      send_request(i);
    @(negedge clk_i);
    exp_push = 1'b0;
    while (!idle)
      @(negedge clk_i);
    // Run on through two refresh intervals
    while (run_cyc < 2 * T_REFI + 32)
      @(negedge clk_i);
    done = 1'b1;
    while (!final_done)
      @(negedge clk_i);
    $display("Errors: data %0d, timing %0d, protocol %0d", data_err, timing_err, proto_err);
    if (data_err + timing_err + proto_err == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    wait (loaded);
    repeat (n_acc * 60 + 2 * T_REFI + 16) @(posedge clk_i);
    $display("Watchdog expired before all accesses completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_sdram_sched

`default_nettype wire
